// ==== chip8_pkg.sv ====
/*
 * Shared widths, host bus address map and enums for the CHIP-8 core.
 * TIMER_TICK_CYCLES is kept small for simulation; raise it for a real 60 Hz tick.
 */
`default_nettype none

package chip8_pkg;

    localparam int ADDR_W    = 12;
    localparam int BYTE_W    = 8;
    localparam int REG_IDX_W = 4;
    localparam int INSTR_W   = 16;

    localparam logic [ADDR_W-1:0] PC_START = 12'h200;

    // Clock cycles per timer tick
    localparam int TIMER_TICK_CYCLES = 16;

    // Host bus address map, V0 to VF sit at 0x00 to ADDR_V_LAST
    localparam logic [17:0] ADDR_V_LAST = 18'h0F;
    localparam logic [17:0] ADDR_I      = 18'h10;
    localparam logic [17:0] ADDR_SOUND  = 18'h11;
    localparam logic [17:0] ADDR_DELAY  = 18'h12;
    localparam logic [17:0] ADDR_PC     = 18'h14;
    localparam logic [17:0] ADDR_STATE  = 18'h16;
    localparam logic [17:0] ADDR_MEM    = 18'h19;

    // Returned for unmapped addresses
    localparam logic [31:0] DEFAULT_READ = 32'd101;

    typedef enum logic [1:0] {
        RUNNING = 2'd0,
        STEP    = 2'd1,
        PAUSED  = 2'd2
    } chip8_state_e;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        COMMIT
    } exec_stage_e;

    typedef enum logic [3:0] {
        JUMP,
        SKIP_EQ,
        SKIP_NE,
        LOAD,
        ADD,
        COPY,
        SET_I,
        GET_DELAY,
        SET_DELAY,
        SET_SOUND,
        NOP
    } opcode_e;

endpackage

`default_nettype wire

// ==== chip8_memory.sv ====
/*
 * 4 KiB byte RAM with registered reads on both ports.
 * Port A is write-first, so a byte written reads back on the next cycle.
 * Contents power up zeroed and are not cleared by reset.
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_memory (
    input  logic                         clk,
    input  logic [chip8_pkg::ADDR_W-1:0] addr_a,
    input  logic [chip8_pkg::ADDR_W-1:0] addr_b,
    input  logic [chip8_pkg::BYTE_W-1:0] wdata_a,
    input  logic                         we_a,
    output logic [chip8_pkg::BYTE_W-1:0] rdata_a,
    output logic [chip8_pkg::BYTE_W-1:0] rdata_b
);

    logic [chip8_pkg::BYTE_W-1:0] mem [2**chip8_pkg::ADDR_W];

    initial begin
        for (int i = 0; i < 2**chip8_pkg::ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[addr_a] <= wdata_a;
            rdata_a     <= wdata_a;
        end else begin
            rdata_a <= mem[addr_a];
        end
    end

    // Read-only port, used for the low instruction byte
    always_ff @(posedge clk) begin
        rdata_b <= mem[addr_b];
    end

endmodule

`default_nettype wire

// ==== chip8_reg_file.sv ====
/*
 * Sixteen 8-bit V registers, two combinational reads, one write port.
 * A write becomes visible on the read ports the cycle after.
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_reg_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [chip8_pkg::REG_IDX_W-1:0] raddr_x,
    input  logic [chip8_pkg::REG_IDX_W-1:0] raddr_y,
    output logic [chip8_pkg::BYTE_W-1:0]    rdata_x,
    output logic [chip8_pkg::BYTE_W-1:0]    rdata_y,
    input  logic [chip8_pkg::REG_IDX_W-1:0] waddr,
    input  logic [chip8_pkg::BYTE_W-1:0]    wdata,
    input  logic                            we
);

    logic [chip8_pkg::BYTE_W-1:0] regs [2**chip8_pkg::REG_IDX_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**chip8_pkg::REG_IDX_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_x = regs[raddr_x];
    assign rdata_y = regs[raddr_y];

endmodule

`default_nettype wire

// ==== chip8_timers.sv ====
/*
 * Delay and sound countdown timers sharing one tick divider.
 * A write loads the counter at once; each nonzero counter drops by one per tick.
 * The divider free-runs in every run state.
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_timers (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         delay_we,
    input  logic                         sound_we,
    input  logic [chip8_pkg::BYTE_W-1:0] delay_wdata,
    input  logic [chip8_pkg::BYTE_W-1:0] sound_wdata,
    output logic [chip8_pkg::BYTE_W-1:0] delay_value,
    output logic [chip8_pkg::BYTE_W-1:0] sound_value
);

    localparam int DIV_W = $clog2(chip8_pkg::TIMER_TICK_CYCLES);

    logic [DIV_W-1:0]             div_count;
    logic                         tick;
    logic [1:0]                   load;
    logic [chip8_pkg::BYTE_W-1:0] load_value [2];
    logic [chip8_pkg::BYTE_W-1:0] count      [2];

    always_ff @(posedge clk) begin
        if (reset || tick) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    assign tick = (div_count == DIV_W'(chip8_pkg::TIMER_TICK_CYCLES - 1));

    // Index 0 is delay, 1 is sound
    assign load          = {sound_we, delay_we};
    assign load_value[0] = delay_wdata;
    assign load_value[1] = sound_wdata;

    always_ff @(posedge clk) begin
        for (int t = 0; t < 2; t++) begin
            if (reset) begin
                count[t] <= '0;
            end else if (load[t]) begin
                count[t] <= load_value[t];
            end else if (tick && count[t] != '0) begin
                count[t] <= count[t] - 1'b1;
            end
        end
    end

    assign delay_value = count[0];
    assign sound_value = count[1];

endmodule

`default_nettype wire

// ==== chip8_exec.sv ====
/*
 * Four-stage sequencer: FETCH, DECODE, EXECUTE, COMMIT, one instruction in flight.
 * Register, I and timer writes land at the end of EXECUTE, PC at the end of COMMIT.
 * Opcodes outside the supported subset act as a no-op that advances PC by 2.
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_exec (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            enable,
    input  logic                            stall,
    input  logic [chip8_pkg::BYTE_W-1:0]    mem_rdata_a,
    input  logic [chip8_pkg::BYTE_W-1:0]    mem_rdata_b,
    input  logic [chip8_pkg::BYTE_W-1:0]    v_x,
    input  logic [chip8_pkg::BYTE_W-1:0]    v_y,
    input  logic [chip8_pkg::BYTE_W-1:0]    delay_value,
    input  logic                            host_pc_we,
    input  logic                            host_i_we,
    input  logic [15:0]                     host_wdata,
    output logic [chip8_pkg::ADDR_W-1:0]    fetch_addr,
    output logic                            fetching,
    output logic [chip8_pkg::REG_IDX_W-1:0] reg_x,
    output logic [chip8_pkg::REG_IDX_W-1:0] reg_y,
    output logic                            reg_we,
    output logic [chip8_pkg::BYTE_W-1:0]    reg_wdata,
    output logic                            delay_we,
    output logic                            sound_we,
    output logic [chip8_pkg::BYTE_W-1:0]    timer_wdata,
    output logic [chip8_pkg::ADDR_W-1:0]    pc,
    output logic [15:0]                     index_reg,
    output logic                            retired
);

    chip8_pkg::exec_stage_e         stage;
    chip8_pkg::opcode_e             op;
    logic [chip8_pkg::INSTR_W-1:0]  instr;
    logic [chip8_pkg::BYTE_W-1:0]   nn;
    logic [chip8_pkg::ADDR_W-1:0]   next_pc;
    logic                           active;
    logic                           fetched;
    logic                           skip_taken;
    logic                           executing;

    function automatic chip8_pkg::opcode_e decode(input logic [chip8_pkg::INSTR_W-1:0] word);
        chip8_pkg::opcode_e res;
        res = chip8_pkg::NOP;
        case (word[15:12])
            4'h1: res = chip8_pkg::JUMP;
            4'h3: res = chip8_pkg::SKIP_EQ;
            4'h4: res = chip8_pkg::SKIP_NE;
            4'h6: res = chip8_pkg::LOAD;
            4'h7: res = chip8_pkg::ADD;
            4'h8: if (word[3:0] == 4'h0) res = chip8_pkg::COPY;
            4'hA: res = chip8_pkg::SET_I;
            4'hF: begin
                case (word[7:0])
                    8'h07: res = chip8_pkg::GET_DELAY;
                    8'h15: res = chip8_pkg::SET_DELAY;
                    8'h18: res = chip8_pkg::SET_SOUND;
                    default: res = chip8_pkg::NOP;
                endcase
            end
            default: res = chip8_pkg::NOP;
        endcase
        return res;
    endfunction

    assign active     = enable && !stall;
    assign fetching   = active && (stage == chip8_pkg::FETCH);
    assign executing  = active && (stage == chip8_pkg::EXECUTE);
    assign retired    = active && (stage == chip8_pkg::COMMIT);
    assign fetch_addr = pc;

    assign nn          = instr[7:0];
    assign reg_x       = instr[11:8];
    assign reg_y       = instr[7:4];
    assign timer_wdata = v_x;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= chip8_pkg::FETCH;
        end else if (active) begin
            case (stage)
                chip8_pkg::FETCH:   stage <= chip8_pkg::DECODE;
                chip8_pkg::DECODE:  stage <= chip8_pkg::EXECUTE;
                chip8_pkg::EXECUTE: stage <= chip8_pkg::COMMIT;
                default:            stage <= chip8_pkg::FETCH;
            endcase
        end
    end

    // Memory output is only valid right after a real fetch cycle,
    // a stall in DECODE hands port A back to the host
    always_ff @(posedge clk) begin
        if (reset) begin
            fetched <= 1'b0;
        end else begin
            fetched <= fetching;
        end
    end

    always_ff @(posedge clk) begin
        if (stage == chip8_pkg::DECODE && fetched) begin
            instr <= {mem_rdata_a, mem_rdata_b};
            op    <= decode({mem_rdata_a, mem_rdata_b});
        end
    end

    // Write-back
    always_comb begin
        reg_we    = 1'b0;
        delay_we  = 1'b0;
        sound_we  = 1'b0;
        reg_wdata = nn;
        case (op)
            chip8_pkg::LOAD: reg_we = executing;
            chip8_pkg::ADD: begin
                reg_we    = executing;
                reg_wdata = v_x + nn;
            end
            chip8_pkg::COPY: begin
                reg_we    = executing;
                reg_wdata = v_y;
            end
            chip8_pkg::GET_DELAY: begin
                reg_we    = executing;
                reg_wdata = delay_value;
            end
            chip8_pkg::SET_DELAY: delay_we = executing;
            chip8_pkg::SET_SOUND: sound_we = executing;
            default: reg_wdata = nn;
        endcase
    end

    assign skip_taken = (op == chip8_pkg::SKIP_EQ && v_x == nn) ||
                        (op == chip8_pkg::SKIP_NE && v_x != nn);

    always_ff @(posedge clk) begin
        if (executing) begin
            if (op == chip8_pkg::JUMP) begin
                next_pc <= instr[11:0];
            end else if (skip_taken) begin
                next_pc <= pc + 12'd4;
            end else begin
                next_pc <= pc + 12'd2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= chip8_pkg::PC_START;
            index_reg <= '0;
        end else begin
            if (host_pc_we) begin
                pc <= host_wdata[chip8_pkg::ADDR_W-1:0];
            end else if (retired) begin
                pc <= next_pc;
            end
            if (host_i_we) begin
                index_reg <= host_wdata;
            end else if (executing && op == chip8_pkg::SET_I) begin
                index_reg <= {4'h0, instr[11:0]};
            end
        end
    end

endmodule

`default_nettype wire

// ==== chip8_top.sv ====
/*
 * CHIP-8 core with a plain chipselect/write host bus, no handshake.
 * Any chipselect cycle stalls the sequencer for that cycle.
 * Memory reads through the bus are exact only while the core is paused.
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [17:0] address,
    input  logic [31:0] writedata,
    output logic [31:0] data_out,
    output logic        sound_on
);

    chip8_pkg::chip8_state_e state;

    logic [chip8_pkg::ADDR_W-1:0]    mem_addr_q;
    logic [chip8_pkg::ADDR_W-1:0]    host_mem_addr;
    logic [chip8_pkg::ADDR_W-1:0]    mem_addr_a;
    logic [chip8_pkg::BYTE_W-1:0]    mem_rdata_a;
    logic [chip8_pkg::BYTE_W-1:0]    mem_rdata_b;
    logic                            mem_we;

    logic                            bus_wr;
    logic                            host_v_we;
    logic                            host_delay_we;
    logic                            host_sound_we;
    logic [chip8_pkg::REG_IDX_W-1:0] rf_raddr_x;
    logic [chip8_pkg::BYTE_W-1:0]    rf_rdata_x;
    logic [chip8_pkg::BYTE_W-1:0]    rf_rdata_y;
    logic [chip8_pkg::REG_IDX_W-1:0] rf_waddr;
    logic [chip8_pkg::BYTE_W-1:0]    rf_wdata;

    logic [chip8_pkg::BYTE_W-1:0]    delay_value;
    logic [chip8_pkg::BYTE_W-1:0]    sound_value;

    logic [chip8_pkg::ADDR_W-1:0]    fetch_addr;
    logic                            fetching;
    logic [chip8_pkg::REG_IDX_W-1:0] exec_reg_x;
    logic [chip8_pkg::REG_IDX_W-1:0] exec_reg_y;
    logic                            exec_reg_we;
    logic [chip8_pkg::BYTE_W-1:0]    exec_reg_wdata;
    logic                            exec_delay_we;
    logic                            exec_sound_we;
    logic [chip8_pkg::BYTE_W-1:0]    exec_timer_wdata;
    logic [chip8_pkg::ADDR_W-1:0]    pc;
    logic [15:0]                     index_reg;
    logic                            retired;
    logic [31:0]                     read_value;

    assign bus_wr        = chipselect && write;
    assign host_v_we     = bus_wr && (address <= chip8_pkg::ADDR_V_LAST);
    assign host_delay_we = bus_wr && (address == chip8_pkg::ADDR_DELAY);
    assign host_sound_we = bus_wr && (address == chip8_pkg::ADDR_SOUND);
    assign mem_we = bus_wr && (address == chip8_pkg::ADDR_MEM) && writedata[20];

    // A memory write addresses port A directly in its own cycle
    assign host_mem_addr = (bus_wr && address == chip8_pkg::ADDR_MEM) ?
                           writedata[19:8] : mem_addr_q;
    assign mem_addr_a    = fetching ? fetch_addr : host_mem_addr;

    // Host owns the V ports during a chipselect cycle
    assign rf_raddr_x = chipselect ? address[chip8_pkg::REG_IDX_W-1:0] : exec_reg_x;
    assign rf_waddr   = chipselect ? address[chip8_pkg::REG_IDX_W-1:0] : exec_reg_x;
    assign rf_wdata   = chipselect ? writedata[chip8_pkg::BYTE_W-1:0] : exec_reg_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= chip8_pkg::PAUSED;
            mem_addr_q <= '0;
        end else begin
            if (bus_wr && address == chip8_pkg::ADDR_STATE) begin
                state <= (writedata[1:0] == 2'd3) ? chip8_pkg::PAUSED :
                         chip8_pkg::chip8_state_e'(writedata[1:0]);
            end else if (state == chip8_pkg::STEP && retired) begin
                state <= chip8_pkg::PAUSED;
            end
            if (bus_wr && address == chip8_pkg::ADDR_MEM) begin
                mem_addr_q <= writedata[19:8];
            end
        end
    end

    always_comb begin
        if (address <= chip8_pkg::ADDR_V_LAST) begin
            read_value = {24'h0, rf_rdata_x};
        end else begin
            case (address)
                chip8_pkg::ADDR_I:     read_value = {16'h0, index_reg};
                chip8_pkg::ADDR_SOUND: read_value = {24'h0, sound_value};
                chip8_pkg::ADDR_DELAY: read_value = {24'h0, delay_value};
                chip8_pkg::ADDR_PC:    read_value = {20'h0, pc};
                chip8_pkg::ADDR_STATE: read_value = {30'h0, state};
                chip8_pkg::ADDR_MEM:   read_value = {12'h0, mem_addr_q, mem_rdata_a};
                default:               read_value = chip8_pkg::DEFAULT_READ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_out <= '0;
        end else if (chipselect) begin
            data_out <= read_value;
        end
    end

    assign sound_on = (state == chip8_pkg::RUNNING) && (sound_value != '0);

    chip8_memory u_memory (
        .clk     (clk),
        .addr_a  (mem_addr_a),
        .addr_b  (mem_addr_a + 1'b1),
        .wdata_a (writedata[chip8_pkg::BYTE_W-1:0]),
        .we_a    (mem_we),
        .rdata_a (mem_rdata_a),
        .rdata_b (mem_rdata_b)
    );

    chip8_reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .raddr_x (rf_raddr_x),
        .raddr_y (exec_reg_y),
        .rdata_x (rf_rdata_x),
        .rdata_y (rf_rdata_y),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .we      (host_v_we || exec_reg_we)
    );

    chip8_timers u_timers (
        .clk         (clk),
        .reset       (reset),
        .delay_we    (host_delay_we || exec_delay_we),
        .sound_we    (host_sound_we || exec_sound_we),
        .delay_wdata (chipselect ? writedata[chip8_pkg::BYTE_W-1:0] : exec_timer_wdata),
        .sound_wdata (chipselect ? writedata[chip8_pkg::BYTE_W-1:0] : exec_timer_wdata),
        .delay_value (delay_value),
        .sound_value (sound_value)
    );

    chip8_exec u_exec (
        .clk         (clk),
        .reset       (reset),
        .enable      (state != chip8_pkg::PAUSED),
        .stall       (chipselect),
        .mem_rdata_a (mem_rdata_a),
        .mem_rdata_b (mem_rdata_b),
        .v_x         (rf_rdata_x),
        .v_y         (rf_rdata_y),
        .delay_value (delay_value),
        .host_pc_we  (bus_wr && address == chip8_pkg::ADDR_PC),
        .host_i_we   (bus_wr && address == chip8_pkg::ADDR_I),
        .host_wdata  (writedata[15:0]),
        .fetch_addr  (fetch_addr),
        .fetching    (fetching),
        .reg_x       (exec_reg_x),
        .reg_y       (exec_reg_y),
        .reg_we      (exec_reg_we),
        .reg_wdata   (exec_reg_wdata),
        .delay_we    (exec_delay_we),
        .sound_we    (exec_sound_we),
        .timer_wdata (exec_timer_wdata),
        .pc          (pc),
        .index_reg   (index_reg),
        .retired     (retired)
    );

endmodule

`default_nettype wire

// ==== tb_chip8.sv ====
/*
 * Testbench for chip8_top covering bus readback, memory, single step, free run and timers.
 * Random programs use only forward jumps and no FX07, so the model stays exact.
 * FX07 and the delay readback are checked against a tick window instead.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_chip8;

    localparam int STEP_PROGS = 2;
    localparam int STEP_LEN   = 12;
    localparam int RUN_PROGS  = 3;
    localparam int RUN_LEN    = 16;
    localparam int TOTAL_INSTR = STEP_PROGS * STEP_LEN + RUN_PROGS * (RUN_LEN + 2);
    // Four cycles per instruction with a margin of 4 on top of a fixed allowance
    localparam int CYCLE_LIMIT = TOTAL_INSTR * 4 * 4 + 2000;

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [17:0] address;
    logic [31:0] writedata;
    logic [31:0] data_out;
    logic        sound_on;

    integer seed = 32'hf23b_c9f7;
    int     cycles = 0;

    // Reference model state
    logic [chip8_pkg::BYTE_W-1:0] mem_m [4096];
    logic [chip8_pkg::BYTE_W-1:0] v_m   [16];
    logic [15:0]                  i_m;
    logic [chip8_pkg::ADDR_W-1:0] pc_m;

    chip8_top UUT (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .data_out   (data_out),
        .sound_on   (sound_on)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            report_failure("timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [chip8_pkg::BYTE_W-1:0] got,
                              input logic [chip8_pkg::BYTE_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [chip8_pkg::ADDR_W-1:0] got,
                              input logic [chip8_pkg::ADDR_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_state(input string name, input chip8_pkg::chip8_state_e got,
                               input chip8_pkg::chip8_state_e exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Counter loaded with hi may have lost one count per tick since the load
    task automatic check_window(input string name, input logic [7:0] got,
                                input int hi, input int elapsed);
        int lo;
        lo = hi - elapsed / chip8_pkg::TIMER_TICK_CYCLES - 1;
        if (int'(got) > hi || int'(got) < lo) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h to 0x%h",
                                     name, got, lo, hi));
        end
    endtask

    task automatic bus_write(input logic [17:0] addr, input logic [31:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= data;
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
    endtask

    task automatic bus_read(input logic [17:0] addr, output logic [31:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= 1'b0;
        address    <= addr;
        @(posedge clk);
        chipselect <= 1'b0;
        @(negedge clk);
        data = data_out;
    endtask

    // Write and read back to back so the sequencer stays stalled between them
    task automatic write_then_read(input logic [17:0] addr, input logic [31:0] wdata,
                                   output logic [31:0] rdata);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= wdata;
        @(posedge clk);
        write <= 1'b0;
        @(posedge clk);
        chipselect <= 1'b0;
        @(negedge clk);
        rdata = data_out;
    endtask

    task automatic load_byte(input logic [11:0] addr, input logic [7:0] data);
        bus_write(chip8_pkg::ADDR_MEM, {11'h0, 1'b1, addr, data});
        mem_m[addr] = data;
    endtask

    task automatic wait_paused();
        logic [31:0] d;
        int          polls;
        polls = 0;
        do begin
            bus_read(chip8_pkg::ADDR_STATE, d);
            polls++;
            if (polls > 40) begin
                report_failure("core did not return to PAUSED after a step");
            end
        end while (d[1:0] != 2'(chip8_pkg::PAUSED));
    endtask

    // Finishes the instruction in flight, then the core rests at FETCH
    task automatic drain_to_paused();
        bus_write(chip8_pkg::ADDR_STATE, 32'(chip8_pkg::STEP));
        wait_paused();
    endtask

    task automatic model_step();
        logic [15:0] w;
        logic [3:0]  x;
        logic [7:0]  nn;
        logic [11:0] nxt;
        w   = {mem_m[pc_m], mem_m[pc_m + 12'd1]};
        x   = w[11:8];
        nn  = w[7:0];
        nxt = pc_m + 12'd2;
        case (w[15:12])
            4'h1: nxt = w[11:0];
            4'h3: if (v_m[x] == nn) nxt = pc_m + 12'd4;
            4'h4: if (v_m[x] != nn) nxt = pc_m + 12'd4;
            4'h6: v_m[x] = nn;
            4'h7: v_m[x] = v_m[x] + nn;
            4'h8: if (w[3:0] == 4'h0) v_m[x] = v_m[w[7:4]];
            4'hA: i_m = {4'h0, w[11:0]};
            default: ;
        endcase
        pc_m = nxt;
    endtask

    task automatic gen_instr(input int k, input int len, output logic [15:0] w);
        logic [31:0] r;
        int          sel;
        int          tgt;
        r   = $random(seed);
        sel = {$random(seed)} % 10;
        case (sel)
            0: begin
                tgt = int'(chip8_pkg::PC_START) + 2 * (k + 1 + {$random(seed)} % (len - k));
                w   = {4'h1, 12'(tgt)};
            end
            1: w = {4'h3, r[11:8], 8'({$random(seed)} % 4)};
            2: w = {4'h4, r[11:8], 8'({$random(seed)} % 4)};
            3: w = {4'h6, r[11:8], r[0] ? 8'(r[7:1] % 4) : r[23:16]};
            4: w = {4'h7, r[11:0]};
            5: w = {4'h8, r[11:4], 4'h0};
            6: w = {4'hA, r[11:0]};
            7: w = {4'hF, r[11:8], 8'h15};
            8: w = {4'hF, r[11:8], 8'h18};
            default: w = {4'hE, r[11:0]};
        endcase
    endtask

    // With halt set, two jump-to-self words follow, so a skip cannot escape
    task automatic load_program(input int len, input bit halt);
        logic [15:0] w;
        logic [11:0] a;
        for (int k = 0; k < len + (halt ? 2 : 0); k++) begin
            a = chip8_pkg::PC_START + 12'(2 * k);
            if (k < len) begin
                gen_instr(k, len, w);
            end else begin
                w = {4'h1, a};
            end
            load_byte(a, w[15:8]);
            load_byte(a + 12'd1, w[7:0]);
        end
    endtask

    task automatic compare_core();
        logic [31:0] d;
        bus_read(chip8_pkg::ADDR_PC, d);
        check_addr("pc", d[11:0], pc_m);
        bus_read(chip8_pkg::ADDR_I, d);
        check_word("i", d, {16'h0, i_m});
        for (int k = 0; k < 16; k++) begin
            bus_read(18'(k), d);
            check_byte($sformatf("v%0d", k), d[7:0], v_m[k]);
        end
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] r;
        logic [11:0] addrs [24];
        logic [17:0] unmapped [4];
        logic [3:0]  x;
        int          start;
        int          dval;
        int          steps;
        logic [11:0] prev;

        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        reset      = 1'b1;
        for (int a = 0; a < 4096; a++) begin
            mem_m[a] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (sound_on !== 1'b0) begin
            report_failure("sound_on is high after reset");
        end

        // Bus register readback while PAUSED
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            v_m[k] = r[7:0];
            bus_write(18'(k), r);
        end
        r = $random(seed);
        i_m  = r[15:0];
        pc_m = r[27:16];
        bus_write(chip8_pkg::ADDR_I, r);
        bus_write(chip8_pkg::ADDR_PC, {20'h0, pc_m});
        compare_core();
        unmapped = '{18'h13, 18'h17, 18'h100, 18'h3FFFF};
        for (int k = 0; k < 4; k++) begin
            bus_read(unmapped[k], d);
            check_word("unmapped read", d, chip8_pkg::DEFAULT_READ);
        end

        // Memory access in the upper half, away from the programs
        for (int k = 0; k < 24; k++) begin
            r = $random(seed);
            addrs[k] = {1'b1, r[10:0]};
            load_byte(addrs[k], r[23:16]);
        end
        for (int k = 0; k < 24; k++) begin
            bus_write(chip8_pkg::ADDR_MEM, {12'h0, addrs[k], 8'h0});
            bus_read(chip8_pkg::ADDR_MEM, d);
            check_word("mem", d, {12'h0, addrs[k], mem_m[addrs[k]]});
        end

        // Single step
        for (int p = 0; p < STEP_PROGS; p++) begin
            pc_m = chip8_pkg::PC_START;
            bus_write(chip8_pkg::ADDR_PC, {20'h0, pc_m});
            load_program(STEP_LEN, 1'b0);
            for (int s = 0; s < STEP_LEN; s++) begin
                bus_write(chip8_pkg::ADDR_STATE, 32'(chip8_pkg::STEP));
                wait_paused();
                model_step();
                compare_core();
            end
        end

        // FX07 reads a delay counter that is already counting down
        r = $random(seed);
        x = r[3:0];
        pc_m = 12'h400;
        bus_write(chip8_pkg::ADDR_PC, {20'h0, pc_m});
        load_byte(12'h400, {4'hF, x});
        load_byte(12'h401, 8'h07);
        start = cycles;
        bus_write(chip8_pkg::ADDR_DELAY, 32'd200);
        drain_to_paused();
        bus_read(18'(x), d);
        check_window("fx07 result", d[7:0], 200, cycles - start);
        v_m[x] = d[7:0];
        pc_m   = 12'h402;
        compare_core();

        // Free run
        for (int p = 0; p < RUN_PROGS; p++) begin
            pc_m = chip8_pkg::PC_START;
            bus_write(chip8_pkg::ADDR_PC, {20'h0, pc_m});
            load_program(RUN_LEN, 1'b1);
            steps = 0;
            do begin
                prev = pc_m;
                model_step();
                steps++;
            end while (pc_m != prev && steps < 4 * RUN_LEN);
            bus_write(chip8_pkg::ADDR_STATE, 32'(chip8_pkg::RUNNING));
            repeat ((RUN_LEN + 2) * 4 + 20) @(posedge clk);
            drain_to_paused();
            compare_core();
        end

        // State register readback with the core parked on a jump to itself
        for (int st = 0; st < 4; st++) begin
            write_then_read(chip8_pkg::ADDR_STATE, 32'(st), d);
            check_state("state", chip8_pkg::chip8_state_e'(d[1:0]),
                        (st == 3) ? chip8_pkg::PAUSED : chip8_pkg::chip8_state_e'(st));
        end
        drain_to_paused();

        // Delay readback window
        for (int k = 0; k < 4; k++) begin
            dval  = 50 + {$random(seed)} % 200;
            start = cycles;
            bus_write(chip8_pkg::ADDR_DELAY, 32'(dval));
            repeat ({$random(seed)} % 100) @(posedge clk);
            bus_read(chip8_pkg::ADDR_DELAY, d);
            check_window("delay", d[7:0], dval, cycles - start);
        end

        // Sound in RUNNING, then PAUSED
        bus_write(chip8_pkg::ADDR_STATE, 32'(chip8_pkg::RUNNING));
        bus_write(chip8_pkg::ADDR_SOUND, 32'(2 + {$random(seed)} % 8));
        @(negedge clk);
        if (sound_on !== 1'b1) begin
            report_failure("sound_on did not rise after a sound write in RUNNING");
        end
        steps = 0;
        do begin
            bus_read(chip8_pkg::ADDR_SOUND, d);
            steps++;
            if (steps > 200) begin
                report_failure("sound counter never reached zero");
            end
        end while (d[7:0] != 8'h0);
        @(negedge clk);
        if (sound_on !== 1'b0) begin
            report_failure("sound_on still high with the sound counter at zero");
        end
        bus_write(chip8_pkg::ADDR_SOUND, 32'd200);
        drain_to_paused();
        @(negedge clk);
        if (sound_on !== 1'b0) begin
            report_failure("sound_on is high while PAUSED");
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
chip8_pkg.sv
chip8_memory.sv
chip8_reg_file.sv
chip8_timers.sv
chip8_exec.sv
chip8_top.sv
tb_chip8.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the CHIP-8 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_chip8 -f vlog.f -o sim_chip8
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_chip8 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^\*\*\* PASSED \*\*\*$'; then
    exit 0
else
    echo "Pass message not found"
    exit 1
fi
